// ==== sim.f ====
+incdir+sim
source/axi_cdc_pkg.sv
source/async_fifo.sv
source/axi_channel_cdc.sv
source/slave_axi_async.sv
source/slave_ram.sv
source/axi_cdc_ram_top.sv
sim/tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_top -f sim.f -o tb_top_sim
./obj_dir/tb_top_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// ==== sim/tb_axi_master.svh ====
// one LCG drives every random choice, so the seed fixes the whole run.
logic [31:0] lcg_state = 32'd70567;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic int rand_below(input int n);
    logic [31:0] value;
    value = lcg_next();
    return int'(value[30:8]) % n;
endfunction

// idle cycles in front of a bus beat, only while gaps are enabled.
function automatic int gap_cycles();
    if (!gaps_on || rand_below(4) != 0) begin
        return 0;
    end
    return 1 + rand_below(3);
endfunction

function automatic logic pick_ready();
    return !gaps_on || rand_below(4) != 0;
endfunction

// each driver holds valid and payload until ready was seen before a rising edge.
task automatic drive_aw_stream();
    @(negedge BUS_CLK);
    foreach (wr_req_q[i]) begin
        bus_aw_valid = 1'b0;
        repeat (gap_cycles()) @(negedge BUS_CLK);
        bus_aw       = wr_req_q[i];
        bus_aw_valid = 1'b1;
        while (!bus_aw_ready) @(negedge BUS_CLK);
        @(negedge BUS_CLK);
    end
    bus_aw_valid = 1'b0;
endtask

task automatic drive_w_stream();
    @(negedge BUS_CLK);
    foreach (w_beat_q[i]) begin
        bus_w_valid = 1'b0;
        repeat (gap_cycles()) @(negedge BUS_CLK);
        bus_w       = w_beat_q[i];
        bus_w_valid = 1'b1;
        while (!bus_w_ready) @(negedge BUS_CLK);
        @(negedge BUS_CLK);
    end
    bus_w_valid = 1'b0;
endtask

task automatic drive_ar_stream();
    @(negedge BUS_CLK);
    foreach (rd_req_q[i]) begin
        bus_ar_valid = 1'b0;
        repeat (gap_cycles()) @(negedge BUS_CLK);
        bus_ar       = rd_req_q[i];
        bus_ar_valid = 1'b1;
        while (!bus_ar_ready) @(negedge BUS_CLK);
        @(negedge BUS_CLK);
    end
    bus_ar_valid = 1'b0;
endtask

// ==== sim/tb_top.sv ====
module tb_top;

    localparam int FIFO_DEPTH_LOG2 = axi_cdc_pkg::FIFO_DEPTH_LOG2_DEF;
    localparam int RAM_ADDR_BITS   = axi_cdc_pkg::RAM_ADDR_BITS_DEF;
    localparam int RAM_WORDS       = 1 << RAM_ADDR_BITS;
    localparam int BUS_PERIOD      = 6;
    localparam int FILL_BURSTS     = RAM_WORDS / 8;
    localparam int INCR_BURSTS     = 8;
    localparam int FIXED_BURSTS    = 6;
    localparam int ERR_BURSTS      = 4;
    localparam int QUEUED_BURSTS   = 12;
    localparam int ALL_BURSTS      =
        2 * (FILL_BURSTS + INCR_BURSTS + FIXED_BURSTS + ERR_BURSTS + QUEUED_BURSTS);
    // eight beats with a gap each, plus the round trip through both crossings.
    localparam int WATCH_LIMIT     = ALL_BURSTS * (2 * 8 + 24) * BUS_PERIOD * 4;

    logic SLAVE_CLK = 1'b0;
    logic BUS_CLK   = 1'b1;
    logic SLAVE_RSTN;
    logic BUS_RSTN;
    axi_cdc_pkg::axi_aw_t bus_aw;
    axi_cdc_pkg::axi_aw_t bus_ar;
    axi_cdc_pkg::axi_w_t  bus_w;
    axi_cdc_pkg::axi_b_t  bus_b;
    axi_cdc_pkg::axi_r_t  bus_r;
    logic bus_aw_valid, bus_aw_ready;
    logic bus_ar_valid, bus_ar_ready;
    logic bus_w_valid, bus_w_ready;
    logic bus_b_valid, bus_b_ready;
    logic bus_r_valid, bus_r_ready;
    logic gaps_on;

    logic [7:0]           model_mem [4*RAM_WORDS];
    axi_cdc_pkg::axi_aw_t wr_req_q [$];
    axi_cdc_pkg::axi_w_t  w_beat_q [$];
    axi_cdc_pkg::axi_b_t  exp_b_q [$];
    axi_cdc_pkg::axi_aw_t rd_req_q [$];
    axi_cdc_pkg::axi_r_t  exp_r_q [$];

    `include "tb_axi_master.svh"

    axi_cdc_ram_top #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
        .RAM_ADDR_BITS  (RAM_ADDR_BITS)
    ) dut_i (.*);

    // the bus clock starts high so its falling edges never meet a slave clock edge.
    always #2 SLAVE_CLK = ~SLAVE_CLK;
    always #3 BUS_CLK = ~BUS_CLK;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_b(input string name, input axi_cdc_pkg::axi_b_t exp,
                           input axi_cdc_pkg::axi_b_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("[FAIL] %s: expected id=%h resp=%h, actual id=%h resp=%h",
                name, exp.id, exp.resp, act.id, act.resp));
        end
    endtask

    task automatic check_r(input string name, input axi_cdc_pkg::axi_r_t exp,
                           input axi_cdc_pkg::axi_r_t act);
        if (act !== exp) begin
            stop_with_failure({$sformatf("[FAIL] %s: expected id=%h data=%h resp=%h last=%b,",
                name, exp.id, exp.data, exp.resp, exp.last),
                $sformatf(" actual id=%h data=%h resp=%h last=%b",
                act.id, act.data, act.resp, act.last)});
        end
    endtask

    task automatic check_reset_state(input string name);
        check_bit({name, " aw_ready"}, 1'b0, bus_aw_ready);
        check_bit({name, " ar_ready"}, 1'b0, bus_ar_ready);
        check_bit({name, " w_ready"}, 1'b0, bus_w_ready);
        check_bit({name, " b_valid"}, 1'b0, bus_b_valid);
        check_bit({name, " r_valid"}, 1'b0, bus_r_valid);
    endtask

    // WRAP, reserved bursts and any beat past the last RAM word are errors.
    function automatic logic burst_in_error(input axi_cdc_pkg::axi_aw_t req);
        longint last_word;
        last_word = longint'(req.addr[31:2]);
        if (req.burst == axi_cdc_pkg::burst_incr) begin
            last_word += longint'(req.len);
        end
        if (req.burst != axi_cdc_pkg::burst_incr && req.burst != axi_cdc_pkg::burst_fixed) begin
            return 1'b1;
        end
        return last_word >= RAM_WORDS;
    endfunction

    function automatic axi_cdc_pkg::axi_aw_t build_req(input logic [31:0] addr, input int len,
                                                       input axi_cdc_pkg::burst_e burst);
        axi_cdc_pkg::axi_aw_t req;
        req.id    = 4'(rand_below(16));
        req.addr  = addr;
        req.len   = 8'(len);
        req.burst = burst;
        return req;
    endfunction

    function automatic axi_cdc_pkg::axi_aw_t random_req(input axi_cdc_pkg::burst_e burst);
        int len;
        int span;
        len  = rand_below(8);
        span = (burst == axi_cdc_pkg::burst_incr) ? RAM_WORDS - len : RAM_WORDS;
        return build_req(32'(4 * rand_below(span)), len, burst);
    endfunction

    task automatic queue_write(input axi_cdc_pkg::axi_aw_t req, input logic full_strb);
        axi_cdc_pkg::axi_w_t beat;
        axi_cdc_pkg::axi_b_t resp;
        logic                err;
        int                  word;
        err  = burst_in_error(req);
        word = int'(req.addr[31:2]);
        for (int i = 0; i <= int'(req.len); i++) begin
            beat.data = lcg_next();
            beat.strb = full_strb ? 4'hf : 4'(rand_below(16));
            beat.last = (i == int'(req.len));
            for (int n = 0; n < 4; n++) begin
                if (!err && beat.strb[n]) begin
                    model_mem[4*word+n] = beat.data[8*n +: 8];
                end
            end
            if (req.burst == axi_cdc_pkg::burst_incr) begin
                word++;
            end
            w_beat_q.push_back(beat);
        end
        resp.id   = req.id;
        resp.resp = err ? axi_cdc_pkg::resp_slverr : axi_cdc_pkg::resp_okay;
        wr_req_q.push_back(req);
        exp_b_q.push_back(resp);
    endtask

    task automatic queue_read(input axi_cdc_pkg::axi_aw_t req);
        axi_cdc_pkg::axi_r_t beat;
        logic                err;
        int                  word;
        err  = burst_in_error(req);
        word = int'(req.addr[31:2]);
        for (int i = 0; i <= int'(req.len); i++) begin
            beat.id   = req.id;
            beat.data = '0;
            if (!err) begin
                beat.data = {model_mem[4*word+3], model_mem[4*word+2],
                             model_mem[4*word+1], model_mem[4*word]};
            end
            beat.resp = err ? axi_cdc_pkg::resp_slverr : axi_cdc_pkg::resp_okay;
            beat.last = (i == int'(req.len));
            exp_r_q.push_back(beat);
            if (req.burst == axi_cdc_pkg::burst_incr) begin
                word++;
            end
        end
        rd_req_q.push_back(req);
    endtask

    // a beat counts when valid and ready are both high half a cycle before the rising edge.
    task automatic collect_b(input string name, input int count);
        axi_cdc_pkg::axi_b_t got;
        int                  seen;
        seen = 0;
        while (seen < count) begin
            @(negedge BUS_CLK);
            bus_b_ready = pick_ready();
            if (bus_b_ready && bus_b_valid) begin
                got = bus_b;
                check_b(name, exp_b_q.pop_front(), got);
                seen++;
            end
        end
        @(negedge BUS_CLK);
        bus_b_ready = 1'b0;
    endtask

    task automatic collect_r(input string name, input int count);
        axi_cdc_pkg::axi_r_t got;
        int                  seen;
        seen = 0;
        while (seen < count) begin
            @(negedge BUS_CLK);
            bus_r_ready = pick_ready();
            if (bus_r_ready && bus_r_valid) begin
                got = bus_r;
                check_r(name, exp_r_q.pop_front(), got);
                seen++;
            end
        end
        @(negedge BUS_CLK);
        bus_r_ready = 1'b0;
    endtask

    task automatic run_writes(input string name);
        int count;
        count = exp_b_q.size();
        fork
            drive_aw_stream();
            drive_w_stream();
            collect_b(name, count);
        join
        wr_req_q.delete();
        w_beat_q.delete();
    endtask

    task automatic run_reads(input string name);
        int count;
        count = exp_r_q.size();
        fork
            drive_ar_stream();
            collect_r(name, count);
        join
        rd_req_q.delete();
    endtask

    initial begin
        #(WATCH_LIMIT);
        stop_with_failure($sformatf("timeout: the bursts did not finish within %0d time units",
            WATCH_LIMIT));
    end

    initial begin
        axi_cdc_pkg::axi_aw_t req;
        axi_cdc_pkg::axi_aw_t saved_q [$];
        int                   waited;
        bus_aw       = '0;
        bus_ar       = '0;
        bus_w        = '0;
        bus_aw_valid = 1'b0;
        bus_ar_valid = 1'b0;
        bus_w_valid  = 1'b0;
        bus_b_ready  = 1'b0;
        bus_r_ready  = 1'b0;
        gaps_on      = 1'b0;
        BUS_RSTN     = 1'b0;
        SLAVE_RSTN   = 1'b0;
        fork
            begin
                repeat (3) @(posedge SLAVE_CLK);
                @(negedge SLAVE_CLK);
                SLAVE_RSTN = 1'b1;
            end
        join_none
        repeat (3) begin
            @(posedge BUS_CLK);
            @(negedge BUS_CLK);
            check_reset_state("reset");
        end
        BUS_RSTN = 1'b1;
        waited   = 0;
        while (!(bus_aw_ready && bus_ar_ready && bus_w_ready)) begin
            if (waited == 10) begin
                stop_with_failure("request ready did not rise after both resets released");
            end
            @(negedge BUS_CLK);
            waited++;
        end
        check_bit("after reset b_valid", 1'b0, bus_b_valid);
        check_bit("after reset r_valid", 1'b0, bus_r_valid);

        // every word gets a known value first, so later partial writes can be predicted.
        for (int k = 0; k < FILL_BURSTS; k++) begin
            queue_write(build_req(32'(32 * k), 7, axi_cdc_pkg::burst_incr), 1'b1);
        end
        run_writes("fill");

        for (int k = 0; k < INCR_BURSTS; k++) begin
            req = random_req(axi_cdc_pkg::burst_incr);
            saved_q.push_back(req);
            queue_write(req, 1'b1);
            run_writes("incr write");
        end
        foreach (saved_q[k]) begin
            queue_read(saved_q[k]);
            run_reads("incr read");
        end
        saved_q.delete();

        for (int k = 0; k < FIXED_BURSTS; k++) begin
            req = random_req(axi_cdc_pkg::burst_fixed);
            queue_write(req, 1'b0);
            run_writes("fixed write");
            queue_read(req);
            run_reads("fixed read");
        end

        // full strobes, so any beat that reached the RAM would show in the sweep.
        saved_q.push_back(random_req(axi_cdc_pkg::burst_wrap));
        saved_q.push_back(build_req(32'(4 * (RAM_WORDS - 3)), 7, axi_cdc_pkg::burst_incr));
        saved_q.push_back(build_req(32'(4 * RAM_WORDS), 2, axi_cdc_pkg::burst_fixed));
        saved_q.push_back(build_req(32'h8000_0000, 0, axi_cdc_pkg::burst_incr));
        foreach (saved_q[k]) begin
            queue_write(saved_q[k], 1'b1);
        end
        run_writes("error write");
        foreach (saved_q[k]) begin
            queue_read(saved_q[k]);
        end
        run_reads("error read");
        saved_q.delete();
        for (int k = 0; k < FILL_BURSTS; k++) begin
            queue_read(build_req(32'(32 * k), 7, axi_cdc_pkg::burst_incr));
        end
        run_reads("memory sweep");

        gaps_on = 1'b1;
        for (int k = 0; k < QUEUED_BURSTS; k++) begin
            req = random_req(rand_below(2) == 0 ? axi_cdc_pkg::burst_fixed
                                                : axi_cdc_pkg::burst_incr);
            saved_q.push_back(req);
            queue_write(req, 1'b0);
        end
        run_writes("queued write");
        foreach (saved_q[k]) begin
            queue_read(saved_q[k]);
        end
        run_reads("queued read");
        gaps_on = 1'b0;

        repeat (20) @(negedge BUS_CLK);
        check_bit("extra b_valid", 1'b0, bus_b_valid);
        check_bit("extra r_valid", 1'b0, bus_r_valid);
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== source/axi_cdc_ram_top.sv ====
module axi_cdc_ram_top #(
    parameter int FIFO_DEPTH_LOG2 = axi_cdc_pkg::FIFO_DEPTH_LOG2_DEF,
    parameter int RAM_ADDR_BITS   = axi_cdc_pkg::RAM_ADDR_BITS_DEF
) (
    input  logic                 BUS_CLK,
    input  logic                 BUS_RSTN,
    input  logic                 SLAVE_CLK,
    input  logic                 SLAVE_RSTN,
    input  axi_cdc_pkg::axi_aw_t bus_aw,
    input  logic                 bus_aw_valid,
    output logic                 bus_aw_ready,
    input  axi_cdc_pkg::axi_aw_t bus_ar,
    input  logic                 bus_ar_valid,
    output logic                 bus_ar_ready,
    input  axi_cdc_pkg::axi_w_t  bus_w,
    input  logic                 bus_w_valid,
    output logic                 bus_w_ready,
    output axi_cdc_pkg::axi_b_t  bus_b,
    output logic                 bus_b_valid,
    input  logic                 bus_b_ready,
    output axi_cdc_pkg::axi_r_t  bus_r,
    output logic                 bus_r_valid,
    input  logic                 bus_r_ready
);

    axi_cdc_pkg::axi_aw_t slave_aw;
    axi_cdc_pkg::axi_aw_t slave_ar;
    axi_cdc_pkg::axi_w_t  slave_w;
    axi_cdc_pkg::axi_b_t  slave_b;
    axi_cdc_pkg::axi_r_t  slave_r;
    logic slave_aw_valid, slave_aw_ready;
    logic slave_ar_valid, slave_ar_ready;
    logic slave_w_valid, slave_w_ready;
    logic slave_b_valid, slave_b_ready;
    logic slave_r_valid, slave_r_ready;

    slave_axi_async #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) bridge_i (.*);

    slave_ram #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) ram_i (
        .SLAVE_CLK (SLAVE_CLK),      .SLAVE_RSTN(SLAVE_RSTN),
        .aw        (slave_aw),       .aw_valid  (slave_aw_valid), .aw_ready(slave_aw_ready),
        .w         (slave_w),        .w_valid   (slave_w_valid),  .w_ready (slave_w_ready),
        .b         (slave_b),        .b_valid   (slave_b_valid),  .b_ready (slave_b_ready),
        .ar        (slave_ar),       .ar_valid  (slave_ar_valid), .ar_ready(slave_ar_ready),
        .r         (slave_r),        .r_valid   (slave_r_valid),  .r_ready (slave_r_ready)
    );

endmodule

// ==== source/slave_ram.sv ====
module slave_ram #(
    parameter int RAM_ADDR_BITS = axi_cdc_pkg::RAM_ADDR_BITS_DEF
) (
    input  logic                 SLAVE_CLK,
    input  logic                 SLAVE_RSTN,
    input  axi_cdc_pkg::axi_aw_t aw,
    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  axi_cdc_pkg::axi_w_t  w,
    input  logic                 w_valid,
    output logic                 w_ready,
    output axi_cdc_pkg::axi_b_t  b,
    output logic                 b_valid,
    input  logic                 b_ready,
    input  axi_cdc_pkg::axi_aw_t ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    output axi_cdc_pkg::axi_r_t  r,
    output logic                 r_valid,
    input  logic                 r_ready
);

    typedef enum logic [1:0] {wr_idle, wr_data, wr_resp} wr_state_e;
    typedef enum logic {rd_idle, rd_data} rd_state_e;

    logic [31:0] mem [2**RAM_ADDR_BITS];

    wr_state_e              wr_state;
    rd_state_e              rd_state;
    logic [RAM_ADDR_BITS-1:0] wr_idx;
    logic [RAM_ADDR_BITS-1:0] rd_idx;
    logic [RAM_ADDR_BITS-1:0] rd_next_idx;
    logic [7:0]             wr_len;
    logic [7:0]             wr_cnt;
    logic [7:0]             rd_len;
    logic [7:0]             rd_cnt;
    logic                   wr_incr;
    logic                   wr_err;
    logic                   rd_incr;
    logic                   rd_err;
    logic                   aw_hit;
    logic                   w_hit;
    logic                   b_hit;
    logic                   ar_hit;
    logic                   r_hit;

    // the whole burst is checked up front, so an errored burst never
    // touches memory on any beat.
    function automatic logic burst_err(input axi_cdc_pkg::axi_aw_t req);
        logic [30:0] last_word;
        last_word = {1'b0, req.addr[31:2]};
        if (req.burst == axi_cdc_pkg::burst_incr) begin
            last_word = last_word + 31'(req.len);
        end
        return !(req.burst == axi_cdc_pkg::burst_fixed || req.burst == axi_cdc_pkg::burst_incr)
               || ((last_word >> RAM_ADDR_BITS) != '0);
    endfunction

    assign aw_hit = aw_valid && aw_ready;
    assign w_hit  = w_valid && w_ready;
    assign b_hit  = b_valid && b_ready;
    assign ar_hit = ar_valid && ar_ready;
    assign r_hit  = r_valid && r_ready;

    // write burst FSM. w.last is not trusted, the beat count ends the burst.
    always_ff @(posedge SLAVE_CLK) begin
        if (!SLAVE_RSTN) begin
            wr_state <= wr_idle;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            case (wr_state)
                wr_idle: begin
                    aw_ready <= !aw_hit;
                    if (aw_hit) begin
                        w_ready  <= 1'b1;
                        wr_state <= wr_data;
                    end
                end
                wr_data: begin
                    if (w_hit && wr_cnt == wr_len) begin
                        w_ready  <= 1'b0;
                        b_valid  <= 1'b1;
                        wr_state <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (b_hit) begin
                        b_valid  <= 1'b0;
                        aw_ready <= 1'b1;
                        wr_state <= wr_idle;
                    end
                end
                default: wr_state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (aw_hit) begin
            wr_idx  <= aw.addr[RAM_ADDR_BITS+1:2];
            wr_len  <= aw.len;
            wr_cnt  <= '0;
            wr_incr <= (aw.burst == axi_cdc_pkg::burst_incr);
            wr_err  <= burst_err(aw);
            b.id    <= aw.id;
            b.resp  <= burst_err(aw) ? axi_cdc_pkg::resp_slverr : axi_cdc_pkg::resp_okay;
        end else if (w_hit) begin
            wr_cnt <= wr_cnt + 1'b1;
            if (wr_incr) begin
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (w_hit && !wr_err) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    // read burst FSM. r_valid stays high across the burst while beats
    // are consumed back to back.
    always_ff @(posedge SLAVE_CLK) begin
        if (!SLAVE_RSTN) begin
            rd_state <= rd_idle;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
        end else begin
            case (rd_state)
                rd_idle: begin
                    ar_ready <= !ar_hit;
                    if (ar_hit) begin
                        r_valid  <= 1'b1;
                        rd_state <= rd_data;
                    end
                end
                rd_data: begin
                    if (r_hit && r.last) begin
                        r_valid  <= 1'b0;
                        ar_ready <= 1'b1;
                        rd_state <= rd_idle;
                    end
                end
                default: rd_state <= rd_idle;
            endcase
        end
    end

    assign rd_next_idx = rd_incr ? rd_idx + 1'b1 : rd_idx;

    always_ff @(posedge SLAVE_CLK) begin
        if (ar_hit) begin
            rd_idx  <= ar.addr[RAM_ADDR_BITS+1:2];
            rd_len  <= ar.len;
            rd_cnt  <= '0;
            rd_incr <= (ar.burst == axi_cdc_pkg::burst_incr);
            rd_err  <= burst_err(ar);
            r.id    <= ar.id;
            r.resp  <= burst_err(ar) ? axi_cdc_pkg::resp_slverr : axi_cdc_pkg::resp_okay;
            r.last  <= (ar.len == 8'd0);
            r.data  <= burst_err(ar) ? '0 : mem[ar.addr[RAM_ADDR_BITS+1:2]];
        end else if (r_hit && !r.last) begin
            rd_cnt <= rd_cnt + 1'b1;
            rd_idx <= rd_next_idx;
            r.last <= (rd_cnt + 8'd1 == rd_len);
            r.data <= rd_err ? '0 : mem[rd_next_idx];
        end
    end

endmodule

// ==== source/slave_axi_async.sv ====
module slave_axi_async #(
    parameter int FIFO_DEPTH_LOG2 = axi_cdc_pkg::FIFO_DEPTH_LOG2_DEF
) (
    input  logic                  BUS_CLK,
    input  logic                  BUS_RSTN,
    input  logic                  SLAVE_CLK,
    input  logic                  SLAVE_RSTN,

    input  axi_cdc_pkg::axi_aw_t  bus_aw,
    input  logic                  bus_aw_valid,
    output logic                  bus_aw_ready,
    input  axi_cdc_pkg::axi_aw_t  bus_ar,
    input  logic                  bus_ar_valid,
    output logic                  bus_ar_ready,
    input  axi_cdc_pkg::axi_w_t   bus_w,
    input  logic                  bus_w_valid,
    output logic                  bus_w_ready,
    output axi_cdc_pkg::axi_b_t   bus_b,
    output logic                  bus_b_valid,
    input  logic                  bus_b_ready,
    output axi_cdc_pkg::axi_r_t   bus_r,
    output logic                  bus_r_valid,
    input  logic                  bus_r_ready,

    output axi_cdc_pkg::axi_aw_t  slave_aw,
    output logic                  slave_aw_valid,
    input  logic                  slave_aw_ready,
    output axi_cdc_pkg::axi_aw_t  slave_ar,
    output logic                  slave_ar_valid,
    input  logic                  slave_ar_ready,
    output axi_cdc_pkg::axi_w_t   slave_w,
    output logic                  slave_w_valid,
    input  logic                  slave_w_ready,
    input  axi_cdc_pkg::axi_b_t   slave_b,
    input  logic                  slave_b_valid,
    output logic                  slave_b_ready,
    input  axi_cdc_pkg::axi_r_t   slave_r,
    input  logic                  slave_r_valid,
    output logic                  slave_r_ready
);

    localparam int AW_BITS = $bits(axi_cdc_pkg::axi_aw_t);
    localparam int W_BITS  = $bits(axi_cdc_pkg::axi_w_t);
    localparam int B_BITS  = $bits(axi_cdc_pkg::axi_b_t);
    localparam int R_BITS  = $bits(axi_cdc_pkg::axi_r_t);

    // request channels run from the bus into the slave domain.
    axi_channel_cdc #(.WIDTH(AW_BITS), .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) aw_cdc_i (
        .in_clk   (BUS_CLK),      .in_rstn  (BUS_RSTN),
        .out_clk  (SLAVE_CLK),    .out_rstn (SLAVE_RSTN),
        .in_data  (bus_aw),       .in_valid (bus_aw_valid),   .in_ready (bus_aw_ready),
        .out_data (slave_aw),     .out_valid(slave_aw_valid), .out_ready(slave_aw_ready)
    );

    axi_channel_cdc #(.WIDTH(AW_BITS), .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) ar_cdc_i (
        .in_clk   (BUS_CLK),      .in_rstn  (BUS_RSTN),
        .out_clk  (SLAVE_CLK),    .out_rstn (SLAVE_RSTN),
        .in_data  (bus_ar),       .in_valid (bus_ar_valid),   .in_ready (bus_ar_ready),
        .out_data (slave_ar),     .out_valid(slave_ar_valid), .out_ready(slave_ar_ready)
    );

    axi_channel_cdc #(.WIDTH(W_BITS), .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) w_cdc_i (
        .in_clk   (BUS_CLK),      .in_rstn  (BUS_RSTN),
        .out_clk  (SLAVE_CLK),    .out_rstn (SLAVE_RSTN),
        .in_data  (bus_w),        .in_valid (bus_w_valid),    .in_ready (bus_w_ready),
        .out_data (slave_w),      .out_valid(slave_w_valid),  .out_ready(slave_w_ready)
    );

    // response channels are reversed, the slave clock writes the FIFO.
    axi_channel_cdc #(.WIDTH(B_BITS), .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) b_cdc_i (
        .in_clk   (SLAVE_CLK),    .in_rstn  (SLAVE_RSTN),
        .out_clk  (BUS_CLK),      .out_rstn (BUS_RSTN),
        .in_data  (slave_b),      .in_valid (slave_b_valid),  .in_ready (slave_b_ready),
        .out_data (bus_b),        .out_valid(bus_b_valid),    .out_ready(bus_b_ready)
    );

    axi_channel_cdc #(.WIDTH(R_BITS), .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) r_cdc_i (
        .in_clk   (SLAVE_CLK),    .in_rstn  (SLAVE_RSTN),
        .out_clk  (BUS_CLK),      .out_rstn (BUS_RSTN),
        .in_data  (slave_r),      .in_valid (slave_r_valid),  .in_ready (slave_r_ready),
        .out_data (bus_r),        .out_valid(bus_r_valid),    .out_ready(bus_r_ready)
    );

endmodule

// ==== source/axi_channel_cdc.sv ====
module axi_channel_cdc #(
    parameter int WIDTH           = 32,
    parameter int FIFO_DEPTH_LOG2 = axi_cdc_pkg::FIFO_DEPTH_LOG2_DEF
) (
    input  logic             in_clk,
    input  logic             in_rstn,
    input  logic             out_clk,
    input  logic             out_rstn,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    logic             fifo_full;
    logic             fifo_empty;
    logic             fifo_rd_en;
    logic [WIDTH-1:0] fifo_rd_data;
    logic             slot_empty;
    logic             out_hit;

    // no new beats are taken until both sides are out of reset.
    assign in_ready   = in_rstn && out_rstn && !fifo_full;

    assign out_hit    = out_valid && out_ready;
    assign fifo_rd_en = !fifo_empty && (slot_empty || out_hit);

    async_fifo #(
        .WIDTH          (WIDTH),
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) fifo_i (
        .wr_clk  (in_clk),
        .wr_rst  (!in_rstn),
        .wr_en   (in_valid && in_ready),
        .wr_data (in_data),
        .wr_full (fifo_full),
        .rd_clk  (out_clk),
        .rd_rst  (!out_rstn),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .rd_empty(fifo_empty)
    );

    // the output register is refilled on the same edge it hands off,
    // so a full FIFO streams one beat per out_clk.
    always_ff @(posedge out_clk) begin
        if (!out_rstn) begin
            slot_empty <= 1'b1;
        end else if (fifo_rd_en) begin
            slot_empty <= 1'b0;
        end else if (out_hit) begin
            slot_empty <= 1'b1;
        end
    end

    always_ff @(posedge out_clk) begin
        if (fifo_rd_en) begin
            out_data <= fifo_rd_data;
        end
    end

    assign out_valid = !slot_empty;

endmodule

// ==== source/async_fifo.sv ====
module async_fifo #(
    parameter int WIDTH           = 32,
    parameter int FIFO_DEPTH_LOG2 = axi_cdc_pkg::FIFO_DEPTH_LOG2_DEF
) (
    input  logic             wr_clk,
    input  logic             wr_rst,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    output logic             wr_full,
    input  logic             rd_clk,
    input  logic             rd_rst,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_empty
);

    localparam int A = FIFO_DEPTH_LOG2;

    logic [WIDTH-1:0] mem [2**A];

    // pointers carry one extra bit to tell full from empty.
    logic [A:0] wr_bin;
    logic [A:0] wr_bin_inc;
    logic [A:0] wr_gray;
    logic [A:0] rd_bin;
    logic [A:0] rd_bin_inc;
    logic [A:0] rd_gray;
    logic [A:0] rd_gray_s1;
    logic [A:0] rd_gray_s2;
    logic [A:0] wr_gray_s1;
    logic [A:0] wr_gray_s2;
    logic       push;
    logic       pop;

    function automatic logic [A:0] to_gray(input logic [A:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    assign push       = wr_en && !wr_full;
    assign pop        = rd_en && !rd_empty;
    assign wr_bin_inc = wr_bin + 1'b1;
    assign rd_bin_inc = rd_bin + 1'b1;

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            if (push) begin
                wr_bin  <= wr_bin_inc;
                wr_gray <= to_gray(wr_bin_inc);
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (push) begin
            mem[wr_bin[A-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            if (pop) begin
                rd_bin  <= rd_bin_inc;
                rd_gray <= to_gray(rd_bin_inc);
            end
        end
    end

    // full when the write pointer is one lap ahead, which in Gray code
    // means the top two bits differ and the rest match.
    assign wr_full  = (wr_gray == {~rd_gray_s2[A:A-1], rd_gray_s2[A-2:0]});
    assign rd_empty = (rd_gray == wr_gray_s2);

    // first-word fall-through, the head entry is always visible.
    assign rd_data  = mem[rd_bin[A-1:0]];

endmodule

// ==== source/axi_cdc_pkg.sv ====
package axi_cdc_pkg;

    // burst encodings follow the AXI4 AxBURST field.
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } burst_e;

    // only OKAY and SLVERR are produced by the RAM slave.
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_e;

    // address request, shared by the AW and AR channels.
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        burst_e      burst;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [3:0] id;
        resp_e      resp;
    } axi_b_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        resp_e       resp;
        logic        last;
    } axi_r_t;

    // eight entries per crossing FIFO.
    localparam int FIFO_DEPTH_LOG2_DEF = 3;

    // 256 words of 32 bits.
    localparam int RAM_ADDR_BITS_DEF = 8;

endpackage
